// ==== src/ps_pio_regs_pkg.sv ====
package ps_pio_regs_pkg;

    typedef logic [7:0]  cmd_byte_t;        // one byte on command/status bus
    typedef logic [4:0]  reg_addr_t;        // register offset after decode
    typedef logic [15:0] reg_data_t;        // write payload, d1:d0
    typedef logic [1:0]  status_payload_t;  // {half_full, active}

    localparam int cmd_bytes = 4;           // al, ah, d0, d1

    // register offsets within the decoded window
    localparam reg_addr_t reg_en_rst       = 5'h0;  // bit1 enable, bit0 run
    localparam reg_addr_t reg_cmd          = 5'h1;  // push sequencer command
    localparam reg_addr_t reg_status_cntrl = 5'h2;  // status mode + seq number

endpackage

// ==== src/ps_pio_chan_pkg.sv ====
package ps_pio_chan_pkg;

    typedef logic [13:0] cmd_word_t;   // {chn, need, page, seq_addr}
    typedef logic [9:0]  seq_addr_t;   // sequencer program address
    typedef logic [1:0]  page_t;       // one of 4 buffer pages
    typedef logic [6:0]  buf_waddr_t;  // 64-bit word within page
    typedef logic [63:0] word64_t;     // memory side
    typedef logic [31:0] word32_t;     // port side
    typedef logic [9:0]  port_addr_t;  // {page, 32-bit word}

    localparam int buf_addr_w = $bits(page_t) + $bits(buf_waddr_t);  // memory side incl page

    // cmd_word_t field positions
    localparam int cmd_page_lsb = 10;
    localparam int cmd_need_bit = 12;
    localparam int cmd_chn_bit  = 13;  // 0 read to port0, 1 write from port1

endpackage

// ==== src/cmd_deser.sv ====
`timescale 1ns/1ps

module cmd_deser #(
    parameter logic [15:0] ps_addr = 16'h100,
    parameter logic [15:0] ps_mask = 16'h3e0
) (
    input  logic                       rst,   // clock
    input  logic                       mclk,  // async reset
    input  ps_pio_regs_pkg::cmd_byte_t ad,
    input  logic                       stb,   // marks first byte
    output ps_pio_regs_pkg::reg_addr_t addr,
    output ps_pio_regs_pkg::reg_data_t data,
    output logic                       we
);

    localparam int nb = ps_pio_regs_pkg::cmd_bytes;

    logic [2:0]      cnt;    // 0 idle, 1..nb-1 shifting, nb decode
    logic [8*nb-1:0] sr;     // {d1, d0, ah, al} once full
    logic            shift;
    logic            match;

    assign shift = stb || (cnt != 3'd0 && cnt != 3'(nb));
    assign match = (sr[15:0] & ps_mask) == (ps_addr & ps_mask);  // window compare

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cnt <= '0;
            we  <= 1'b0;
        end else begin
            if (stb)
                cnt <= 3'd1;              // new transfer, may follow decode cycle
            else if (cnt == 3'(nb))
                cnt <= '0;
            else if (cnt != 3'd0)
                cnt <= cnt + 3'd1;
            we <= (cnt == 3'(nb)) && match;  // single-cycle write pulse
        end
    end

    always_ff @(posedge rst) begin
        if (shift)
            sr <= {ad, sr[8*nb-1:8]};     // bytes enter from the top
        if (cnt == 3'(nb)) begin
            addr <= sr[4:0];              // low address bits only
            data <= sr[8*nb-1 -: 16];
        end
    end

    // a new strobe must not cut into bytes still being collected
    a_stb_gap: assert property (@(posedge rst) disable iff (mclk)
        stb |-> (cnt == 3'd0 || cnt == 3'(nb)))
        else $error("cmd_deser: stb during transfer");

endmodule

// ==== src/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                       rst,       // clock
    input  logic                       mclk,      // async reset
    input  logic                       sync_rst,  // held while channel in reset
    input  logic                       we,
    input  logic                       re,
    input  ps_pio_chan_pkg::cmd_word_t data_in,
    output ps_pio_chan_pkg::cmd_word_t data_out,  // head, no read latency
    output logic                       nempty,
    output logic                       half_full
);

    localparam int            pw   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int            cw   = $clog2(fifo_depth + 1);
    localparam logic [pw-1:0] last = pw'(fifo_depth - 1);

    ps_pio_chan_pkg::cmd_word_t mem [fifo_depth];
    logic [pw-1:0] wptr;
    logic [pw-1:0] rptr;
    logic [cw-1:0] count;
    logic          full;
    logic          wr;
    logic          rd;

    assign full      = count == cw'(fifo_depth);
    assign wr        = we && !full;        // push into full queue is lost
    assign rd        = re && nempty;
    assign nempty    = count != '0;
    assign half_full = count >= cw'(fifo_depth / 2);
    assign data_out  = mem[rptr];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (sync_rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr)
                wptr <= (wptr == last) ? '0 : wptr + 1'b1;
            if (rd)
                rptr <= (rptr == last) ? '0 : rptr + 1'b1;
            count <= count + cw'(wr) - cw'(rd);
        end
    end

    always_ff @(posedge rst) begin
        if (wr)
            mem[wptr] <= data_in;
    end

    a_no_overflow: assert property (@(posedge rst) disable iff (mclk)
        (we && !sync_rst) |-> !full)
        else $error("cmd_fifo: write while full, command dropped");

    a_no_underflow: assert property (@(posedge rst) disable iff (mclk)
        (re && !sync_rst) |-> nempty)
        else $error("cmd_fifo: read while empty");

endmodule

// ==== src/status_generate.sv ====
`timescale 1ns/1ps

module status_generate #(
    parameter ps_pio_regs_pkg::cmd_byte_t status_reg_addr = 8'h2
) (
    input  logic                             rst,     // clock
    input  logic                             mclk,    // async reset
    input  logic                             we,      // status_cntrl write
    input  ps_pio_regs_pkg::cmd_byte_t       wd,      // {seq[5:0], mode[1:0]}
    input  ps_pio_regs_pkg::status_payload_t status,
    output ps_pio_regs_pkg::cmd_byte_t       ad,
    output logic                             rq,      // low on last byte
    input  logic                             start    // address byte taken
);

    typedef enum logic [1:0] {st_idle, st_addr, st_payload} state_t;

    state_t                           state;
    logic [1:0]                       mode;       // 0 off, 1 once, 3 on change
    logic [5:0]                       seq;        // echoed in payload byte
    logic                             pending;    // explicit request not yet sent
    ps_pio_regs_pkg::status_payload_t sent;       // payload of last packet
    logic                             auto_send;
    logic                             due;

    assign auto_send = mode == 2'd3;
    assign due       = pending || (auto_send && status != sent);
    assign rq        = state == st_addr;
    assign ad        = (state == st_payload) ? {seq, sent} : status_reg_addr;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state   <= st_idle;
            mode    <= 2'd0;
            seq     <= '0;
            pending <= 1'b0;
            sent    <= '0;
        end else begin
            if (we) begin
                mode <= wd[1:0];
                seq  <= wd[7:2];
            end
            if (we)
                pending <= wd[1:0] != 2'd0;  // any mode sends current status once
            else if (state == st_addr && start)
                pending <= 1'b0;
            case (state)
                st_idle: begin
                    if (due)
                        state <= st_addr;
                end
                st_addr: begin
                    if (start) begin
                        state <= st_payload;
                        sent  <= status;     // latest value incl changes while waiting
                    end
                end
                default: state <= st_idle;   // payload byte lasts one cycle
            endcase
        end
    end

    // receiver takes only an offered address byte
    a_start_in_addr: assert property (@(posedge rst) disable iff (mclk)
        start |-> rq)
        else $error("status_generate: start without an offered address byte");

endmodule

// ==== src/ps_pio_ctrl.sv ====
`timescale 1ns/1ps

module ps_pio_ctrl (
    input  logic                             rst,             // clock
    input  logic                             mclk,            // async reset
    input  ps_pio_regs_pkg::reg_addr_t       reg_addr,
    input  ps_pio_regs_pkg::reg_data_t       reg_data,
    input  logic                             reg_we,
    input  logic                             channel_pgm_en0, // read channel grant
    input  logic                             channel_pgm_en1, // write channel grant
    input  logic                             seq_done0,
    input  logic                             seq_done1,
    input  ps_pio_chan_pkg::cmd_word_t       fifo_head,
    input  logic                             fifo_nempty,
    input  logic                             fifo_half_full,
    output logic                             want_rq0,
    output logic                             need_rq0,
    output logic                             want_rq1,
    output logic                             need_rq1,
    output ps_pio_chan_pkg::seq_addr_t       seq_data0,       // shared by both channels
    output logic                             seq_set0,
    output ps_pio_chan_pkg::page_t           page,
    output logic                             fifo_push,
    output logic                             fifo_pop,
    output logic                             fifo_clear,
    output logic                             status_we,
    output ps_pio_regs_pkg::status_payload_t status_payload
);

    logic [1:0] en_rst;     // {enable, run}
    logic       chn_en;
    logic       chn_rst;
    logic       pgm_en;
    logic       seq_done;
    logic       mem_run;    // granted transfer still running
    logic       busy;
    logic       start;
    logic       cmd_chn;
    logic       cmd_need;

    assign chn_en    = en_rst[1];
    assign chn_rst   = !en_rst[0];    // run bit low holds channel in reset
    assign pgm_en    = channel_pgm_en0 || channel_pgm_en1;
    assign seq_done  = seq_done0 || seq_done1;
    assign cmd_chn   = fifo_head[ps_pio_chan_pkg::cmd_chn_bit];
    assign cmd_need  = fifo_head[ps_pio_chan_pkg::cmd_need_bit];
    assign busy      = want_rq0 || need_rq0 || want_rq1 || need_rq1 || mem_run;
    assign start     = !chn_rst && chn_en && !busy && fifo_nempty;
    assign seq_data0 = ps_pio_chan_pkg::seq_addr_t'(fifo_head);  // low bits of head
    assign fifo_push = reg_we && reg_addr == ps_pio_regs_pkg::reg_cmd;
    assign status_we = reg_we && reg_addr == ps_pio_regs_pkg::reg_status_cntrl;
    assign fifo_pop  = seq_set0;      // head consumed with the set pulse
    assign fifo_clear     = chn_rst;
    assign status_payload = {fifo_half_full, fifo_nempty || busy};

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            en_rst   <= 2'b00;        // disabled and held in reset
            want_rq0 <= 1'b0;
            need_rq0 <= 1'b0;
            want_rq1 <= 1'b0;
            need_rq1 <= 1'b0;
            mem_run  <= 1'b0;
            seq_set0 <= 1'b0;
            page     <= '0;
        end else begin
            if (reg_we && reg_addr == ps_pio_regs_pkg::reg_en_rst)
                en_rst <= reg_data[1:0];
            if (chn_rst || pgm_en) begin
                want_rq0 <= 1'b0;     // grant or reset drops all requests
                need_rq0 <= 1'b0;
                want_rq1 <= 1'b0;
                need_rq1 <= 1'b0;
            end else if (start) begin
                want_rq0 <= !cmd_chn;
                need_rq0 <= !cmd_chn && cmd_need;
                want_rq1 <= cmd_chn;
                need_rq1 <= cmd_chn && cmd_need;
            end
            if (seq_done)
                mem_run <= 1'b0;
            else if (pgm_en)
                mem_run <= 1'b1;
            seq_set0 <= pgm_en && !chn_rst;   // one edge after grant
            if (seq_set0)
                page <= fifo_head[ps_pio_chan_pkg::cmd_page_lsb +: $bits(page)];
        end
    end

    // grant only for the channel that is requesting
    a_grant_req: assert property (@(posedge rst) disable iff (mclk)
        pgm_en |-> (channel_pgm_en0 == want_rq0 && channel_pgm_en1 == want_rq1))
        else $error("ps_pio_ctrl: grant without matching request");

endmodule

// ==== src/port0_buf.sv ====
`timescale 1ns/1ps

module port0_buf (
    input  logic                                   rst,    // clock
    input  logic                                   we,     // memory side write
    input  logic [ps_pio_chan_pkg::buf_addr_w-1:0] waddr,  // {page, word64}
    input  ps_pio_chan_pkg::word64_t               wdata,
    input  logic                                   re,     // stage 1 read
    input  logic                                   regen,  // output register load
    input  ps_pio_chan_pkg::port_addr_t            raddr,  // {page, word32}
    output ps_pio_chan_pkg::word32_t               rdata
);

    ps_pio_chan_pkg::word64_t mem [2**ps_pio_chan_pkg::buf_addr_w];  // 512 x 64
    ps_pio_chan_pkg::word32_t rd_stage;

    always_ff @(posedge rst) begin
        if (we)
            mem[waddr] <= wdata;
        if (re) begin
            if (raddr[0])
                rd_stage <= mem[raddr[9:1]][63:32];  // odd address, upper half
            else
                rd_stage <= mem[raddr[9:1]][31:0];
        end
        if (regen)
            rdata <= rd_stage;
    end

endmodule

// ==== src/port1_buf.sv ====
`timescale 1ns/1ps

module port1_buf (
    input  logic                                   rst,    // clock
    input  logic                                   we,     // port side write
    input  ps_pio_chan_pkg::port_addr_t            waddr,  // {page, word32}
    input  ps_pio_chan_pkg::word32_t               wdata,
    input  logic                                   re,     // memory side read
    input  logic [ps_pio_chan_pkg::buf_addr_w-1:0] raddr,  // {page, word64}
    output ps_pio_chan_pkg::word64_t               rdata   // valid 2 edges after re
);

    ps_pio_chan_pkg::word32_t mem [2**$bits(ps_pio_chan_pkg::port_addr_t)];  // 1k x 32
    ps_pio_chan_pkg::word64_t rd_stage;

    always_ff @(posedge rst) begin
        if (we)
            mem[waddr] <= wdata;
        if (re)
            rd_stage <= {mem[{raddr, 1'b1}], mem[{raddr, 1'b0}]};  // odd word on top
        rdata <= rd_stage;    // holds until next read
    end

endmodule

// ==== src/ps_pio_top.sv ====
`timescale 1ns/1ps

module ps_pio_top #(
    parameter logic [15:0]                ps_addr         = 16'h100,
    parameter logic [15:0]                ps_mask         = 16'h3e0,  // covers both channels
    parameter ps_pio_regs_pkg::cmd_byte_t status_reg_addr = 8'h2,
    parameter int                         fifo_depth      = 4
) (
    input  logic                          rst,             // clock
    input  logic                          mclk,            // async reset
    // command and status buses
    input  ps_pio_regs_pkg::cmd_byte_t    cmd_ad,
    input  logic                          cmd_stb,
    output ps_pio_regs_pkg::cmd_byte_t    status_ad,
    output logic                          status_rq,
    input  logic                          status_start,
    // port 0, read side of memory data
    input  logic                          port0_re,
    input  logic                          port0_regen,
    input  ps_pio_chan_pkg::port_addr_t   port0_addr,
    output ps_pio_chan_pkg::word32_t      port0_data,
    // port 1, data headed to memory
    input  logic                          port1_we,
    input  ps_pio_chan_pkg::port_addr_t   port1_addr,
    input  ps_pio_chan_pkg::word32_t      port1_data,
    // memory controller, channel 0
    output logic                          want_rq0,
    output logic                          need_rq0,
    input  logic                          channel_pgm_en0,
    output ps_pio_chan_pkg::seq_addr_t    seq_data0,
    output logic                          seq_set0,
    input  logic                          seq_done0,
    input  logic                          buf_wr_chn0,
    input  ps_pio_chan_pkg::buf_waddr_t   buf_waddr_chn0,
    input  ps_pio_chan_pkg::word64_t      buf_wdata_chn0,
    // memory controller, channel 1
    output logic                          want_rq1,
    output logic                          need_rq1,
    input  logic                          channel_pgm_en1,
    input  logic                          seq_done1,
    input  logic                          buf_rd_chn1,
    input  ps_pio_chan_pkg::buf_waddr_t   buf_raddr_chn1,
    output ps_pio_chan_pkg::word64_t      buf_rdata_chn1
);

    ps_pio_regs_pkg::reg_addr_t       cmd_a;
    ps_pio_regs_pkg::reg_data_t       cmd_data;
    logic                             cmd_we;
    ps_pio_chan_pkg::cmd_word_t       fifo_in;       // low bits of command payload
    ps_pio_chan_pkg::cmd_word_t       fifo_head;
    logic                             fifo_nempty;
    logic                             fifo_half_full;
    logic                             fifo_push;
    logic                             fifo_pop;
    logic                             fifo_clear;
    logic                             status_we;
    ps_pio_regs_pkg::status_payload_t status_payload;
    ps_pio_chan_pkg::page_t           page;          // page of granted command

    assign fifo_in = ps_pio_chan_pkg::cmd_word_t'(cmd_data);

    cmd_deser #(
        .ps_addr (ps_addr),
        .ps_mask (ps_mask)
    ) u_cmd_deser (
        .rst  (rst),
        .mclk (mclk),
        .ad   (cmd_ad),
        .stb  (cmd_stb),
        .addr (cmd_a),
        .data (cmd_data),
        .we   (cmd_we)
    );

    cmd_fifo #(
        .fifo_depth (fifo_depth)
    ) u_cmd_fifo (
        .rst       (rst),
        .mclk      (mclk),
        .sync_rst  (fifo_clear),
        .we        (fifo_push),
        .re        (fifo_pop),
        .data_in   (fifo_in),
        .data_out  (fifo_head),
        .nempty    (fifo_nempty),
        .half_full (fifo_half_full)
    );

    status_generate #(
        .status_reg_addr (status_reg_addr)
    ) u_status_generate (
        .rst    (rst),
        .mclk   (mclk),
        .we     (status_we),
        .wd     (cmd_data[7:0]),
        .status (status_payload),
        .ad     (status_ad),
        .rq     (status_rq),
        .start  (status_start)
    );

    ps_pio_ctrl u_ps_pio_ctrl (
        .rst             (rst),
        .mclk            (mclk),
        .reg_addr        (cmd_a),
        .reg_data        (cmd_data),
        .reg_we          (cmd_we),
        .channel_pgm_en0 (channel_pgm_en0),
        .channel_pgm_en1 (channel_pgm_en1),
        .seq_done0       (seq_done0),
        .seq_done1       (seq_done1),
        .fifo_head       (fifo_head),
        .fifo_nempty     (fifo_nempty),
        .fifo_half_full  (fifo_half_full),
        .want_rq0        (want_rq0),
        .need_rq0        (need_rq0),
        .want_rq1        (want_rq1),
        .need_rq1        (need_rq1),
        .seq_data0       (seq_data0),
        .seq_set0        (seq_set0),
        .page            (page),
        .fifo_push       (fifo_push),
        .fifo_pop        (fifo_pop),
        .fifo_clear      (fifo_clear),
        .status_we       (status_we),
        .status_payload  (status_payload)
    );

    port0_buf u_port0_buf (
        .rst   (rst),
        .we    (buf_wr_chn0),
        .waddr ({page, buf_waddr_chn0}),
        .wdata (buf_wdata_chn0),
        .re    (port0_re),
        .regen (port0_regen),
        .raddr (port0_addr),
        .rdata (port0_data)
    );

    port1_buf u_port1_buf (
        .rst   (rst),
        .we    (port1_we),
        .waddr (port1_addr),
        .wdata (port1_data),
        .re    (buf_rd_chn1),
        .raddr ({page, buf_raddr_chn1}),
        .rdata (buf_rdata_chn1)
    );

endmodule

// ==== testbench/ps_pio_checker.sv ====
`timescale 1ns/1ps

module ps_pio_checker (
    input  logic        rst,            // clock
    input  logic [7:0]  test_id,
    input  logic        chk,            // compare selected signal this cycle
    input  logic        miss,           // awaited event never came
    input  logic [2:0]  sel,
    input  logic [63:0] exp,
    input  logic        test_end,
    input  logic        summary,
    input  logic        want_rq0,
    input  logic        need_rq0,
    input  logic        want_rq1,
    input  logic        need_rq1,
    input  logic        seq_set0,
    input  logic [9:0]  seq_data0,
    input  logic [31:0] port0_data,
    input  logic [63:0] buf_rdata_chn1,
    input  logic        status_rq,
    input  logic [7:0]  status_ad,
    output int          errors,
    output int          checks
);

    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          test_errs = 0;     // per test
    int          test_chks = 0;
    int          tests = 0;
    logic [63:0] got;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    function automatic string test_name(input logic [7:0] t);
        case (t)
            8'h01:   return "req_ch0";
            8'h02:   return "grant_ch0";
            8'h03:   return "port0_read";
            8'h04:   return "req_ch1";
            8'h05:   return "grant_ch1";
            8'h06:   return "port1_read";
            8'h07:   return "status_once";
            8'h08:   return "status_change";
            8'h09:   return "chan_reset";
            default: return "mask_miss";
        endcase
    endfunction

    // what each select code looks at
    function automatic logic [63:0] actual(input logic [2:0] s);
        case (s)
            3'd0:    return {60'd0, want_rq0, need_rq0, want_rq1, need_rq1};
            3'd1:    return {53'd0, seq_set0, seq_data0};
            3'd2:    return {32'd0, port0_data};
            3'd3:    return buf_rdata_chn1;
            default: return {55'd0, status_rq, status_ad};
        endcase
    endfunction

    always @(posedge rst) begin
        if (chk) begin
            got = actual(sel);           // values held during the cycle just ended
            chk_cnt++;
            test_chks++;
            if (got !== exp) begin
                $display("Fail %s expected %h actual %h", test_name(test_id), exp, got);
                err_cnt++;
                test_errs++;
            end
        end
        if (miss) begin
            if (sel == 3'd0)
                $display("%s: no channel request came up in time", test_name(test_id));
            else
                $display("%s: no status packet was offered in time", test_name(test_id));
            err_cnt++;
            test_errs++;
        end
        if (test_end) begin
            if (test_errs == 0)
                $display("%s: ok, %0d checks", test_name(test_id), test_chks);
            else
                $display("%s: %0d errors in %0d checks", test_name(test_id), test_errs,
                         test_chks);
            tests++;
            test_errs = 0;
            test_chks = 0;
        end
        if (summary)
            $display("tests %0d, checks %0d, errors %0d", tests, chk_cnt, err_cnt);
    end

endmodule

// ==== testbench/tb_ps_pio.sv ====
`timescale 1ns/1ps

module tb_ps_pio;

    localparam int max_vec  = 64;
    localparam int wait_lim = 64;   // cycles allowed for a request or packet

    logic        rst;               // clock
    logic        mclk;              // async reset
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic        status_start;
    logic        port0_re;
    logic        port0_regen;
    logic [9:0]  port0_addr;
    logic [31:0] port0_data;
    logic        port1_we;
    logic [9:0]  port1_addr;
    logic [31:0] port1_data;
    logic        want_rq0;
    logic        need_rq0;
    logic        want_rq1;
    logic        need_rq1;
    logic        channel_pgm_en0;
    logic        channel_pgm_en1;
    logic [9:0]  seq_data0;
    logic        seq_set0;
    logic        seq_done0;
    logic        seq_done1;
    logic        buf_wr_chn0;
    logic [6:0]  buf_waddr_chn0;
    logic [63:0] buf_wdata_chn0;
    logic        buf_rd_chn1;
    logic [6:0]  buf_raddr_chn1;
    logic [63:0] buf_rdata_chn1;

    logic [63:0] vec [max_vec];     // {op, test, addr, data, exp}
    int          nvec = 0;
    logic [7:0]  test_id;
    logic        chk;
    logic        miss;
    logic        test_end;
    logic        summary;
    logic [2:0]  chk_sel;
    logic [63:0] chk_exp;
    int          errors;
    int          checks;
    logic [63:0] wide [8];          // port 0 words as written by memory
    logic [31:0] narrow [16];       // port 1 words as written by the port

    ps_pio_top u_dut (.*);

    ps_pio_checker u_chk (
        .rst (rst), .test_id (test_id), .chk (chk), .miss (miss), .sel (chk_sel),
        .exp (chk_exp), .test_end (test_end), .summary (summary),
        .want_rq0 (want_rq0), .need_rq0 (need_rq0), .want_rq1 (want_rq1),
        .need_rq1 (need_rq1), .seq_set0 (seq_set0), .seq_data0 (seq_data0),
        .port0_data (port0_data), .buf_rdata_chn1 (buf_rdata_chn1),
        .status_rq (status_rq), .status_ad (status_ad),
        .errors (errors), .checks (checks)
    );

    always #10 rst = ~rst;          // 20 ns period

    // checker compares on the next edge
    task automatic request_check(input logic [2:0] s, input logic [63:0] e);
        chk     <= 1'b1;
        chk_sel <= s;
        chk_exp <= e;
        @(posedge rst);
        chk <= 1'b0;
    endtask

    task automatic report_miss(input logic [2:0] s);
        miss    <= 1'b1;
        chk_sel <= s;
        @(posedge rst);
        miss <= 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [15:0] d);
        @(posedge rst);
        cmd_stb <= 1'b1;
        cmd_ad  <= a[7:0];
        @(posedge rst);
        cmd_stb <= 1'b0;
        cmd_ad  <= a[15:8];
        @(posedge rst);
        cmd_ad <= d[7:0];
        @(posedge rst);
        cmd_ad <= d[15:8];          // last byte
    endtask

    task automatic wait_requests(input logic [15:0] e);
        int n;
        n = 0;
        @(posedge rst);
        while (!(want_rq0 || want_rq1) && n < wait_lim) begin
            @(posedge rst);
            n++;
        end
        if (want_rq0 || want_rq1)
            request_check(3'd0, 64'(e));   // held until grant
        else
            report_miss(3'd0);
    endtask

    // grant pulse then set pulse one edge later with requests gone
    task automatic grant_channel(input logic ch, input logic [15:0] e);
        @(posedge rst);
        channel_pgm_en0 <= !ch;
        channel_pgm_en1 <= ch;
        @(posedge rst);
        channel_pgm_en0 <= 1'b0;
        channel_pgm_en1 <= 1'b0;
        request_check(3'd1, 64'(e));
        request_check(3'd0, 64'd0);
    endtask

    task automatic done_pulse(input logic ch);
        @(posedge rst);
        seq_done0 <= !ch;
        seq_done1 <= ch;
        @(posedge rst);
        seq_done0 <= 1'b0;
        seq_done1 <= 1'b0;
    endtask

    // base is {page, word64}
    task automatic port0_test(input logic [8:0] base, input int n);
        logic [9:0] pa;
        for (int i = 0; i < n; i++) begin
            wide[i] = {$urandom, $urandom};
            @(posedge rst);
            buf_wr_chn0    <= 1'b1;
            buf_waddr_chn0 <= base[6:0] + 7'(i);
            buf_wdata_chn0 <= wide[i];
        end
        @(posedge rst);
        buf_wr_chn0 <= 1'b0;
        for (int k = 0; k < 2 * n; k++) begin
            pa = {base + 9'(k / 2), 1'(k % 2)};   // even address low half
            @(posedge rst);
            port0_re   <= 1'b1;
            port0_addr <= pa;
            @(posedge rst);
            port0_re    <= 1'b0;
            port0_regen <= 1'b1;
            @(posedge rst);
            port0_regen <= 1'b0;
            if (k % 2 == 1)
                request_check(3'd2, {32'd0, wide[k / 2][63:32]});
            else
                request_check(3'd2, {32'd0, wide[k / 2][31:0]});
        end
    endtask

    task automatic port1_test(input logic [8:0] base, input int n);
        for (int i = 0; i < 2 * n; i++) begin
            narrow[i] = $urandom;
            @(posedge rst);
            port1_we   <= 1'b1;
            port1_addr <= {base, 1'b0} + 10'(i);
            port1_data <= narrow[i];
        end
        @(posedge rst);
        port1_we <= 1'b0;
        for (int j = 0; j < n; j++) begin
            @(posedge rst);
            buf_rd_chn1    <= 1'b1;
            buf_raddr_chn1 <= base[6:0] + 7'(j);
            @(posedge rst);
            buf_rd_chn1 <= 1'b0;
            @(posedge rst);             // output stage
            request_check(3'd3, {narrow[2 * j + 1], narrow[2 * j]});
        end
    endtask

    // e is {address byte, payload byte}
    task automatic status_packet(input logic [15:0] e);
        int n;
        n = 0;
        @(posedge rst);
        while (!status_rq && n < wait_lim) begin
            @(posedge rst);
            n++;
        end
        if (status_rq) begin
            status_start <= 1'b1;
            request_check(3'd4, {55'd0, 1'b1, e[15:8]});
            status_start <= 1'b0;
            request_check(3'd4, {55'd0, 1'b0, e[7:0]});   // rq low on last byte
        end else begin
            report_miss(3'd4);
        end
    endtask

    initial begin
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] d;
        logic [15:0] e;
        rst = 1'b0;
        mclk = 1'b1;
        {cmd_ad, cmd_stb, status_start, port0_re, port0_regen, port0_addr} = '0;
        {port1_we, port1_addr, port1_data, channel_pgm_en0, channel_pgm_en1} = '0;
        {seq_done0, seq_done1, buf_wr_chn0, buf_waddr_chn0, buf_wdata_chn0} = '0;
        {buf_rd_chn1, buf_raddr_chn1} = '0;
        {test_id, chk, miss, test_end, summary, chk_sel, chk_exp} = '0;
        void'($urandom(32'haf0ab4cc));
        $readmemh("testbench/ps_pio_vectors.txt", vec);
        while (nvec < max_vec && vec[nvec][63:56] != 8'h00)
            nvec++;
        repeat (4) @(posedge rst);
        mclk <= 1'b0;
        for (int i = 0; i < nvec; i++) begin
            op = vec[i][63:56];
            a  = vec[i][47:32];
            d  = vec[i][31:16];
            e  = vec[i][15:0];
            test_id <= vec[i][55:48];
            case (op)
                8'h01: bus_write(a, d);
                8'h02: wait_requests(e);
                8'h03: grant_channel(d[0], e);
                8'h04: done_pulse(d[0]);
                8'h05: port0_test(a[8:0], int'(d));
                8'h06: port1_test(a[8:0], int'(d));
                8'h07: status_packet(e);
                8'h08: repeat (d) @(posedge rst);     // absence window
                8'h09: request_check(3'd0, 64'(e));
                default: begin
                    test_end <= 1'b1;
                    @(posedge rst);
                    test_end <= 1'b0;
                end
            endcase
        end
        @(posedge rst);
        summary <= 1'b1;
        @(posedge rst);
        summary <= 1'b0;
        @(posedge rst);
        if (errors == 0 && checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // budget scales with the vector count
    initial begin
        wait (nvec != 0);
        repeat (nvec * 200) @(posedge rst);
        $display("watchdog: run did not finish within %0d cycles", nvec * 200);
        $display("test failed");
        $finish;
    end

endmodule

// ==== files.f ====
src/ps_pio_regs_pkg.sv
src/ps_pio_chan_pkg.sv
src/cmd_deser.sv
src/cmd_fifo.sv
src/status_generate.sv
src/ps_pio_ctrl.sv
src/port0_buf.sv
src/port1_buf.sv
src/ps_pio_top.sv
testbench/ps_pio_checker.sv
testbench/tb_ps_pio.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run from the project root, decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ps_pio \
    -f files.f -o sim_ps_pio > build.log 2>&1 \
    && ./obj_dir/sim_ps_pio > sim.log 2>&1 \
    || { echo "build or simulation aborted"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "test passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== testbench/ps_pio_vectors.txt ====
// columns op_test_addr_data_exp, op 01 bus write, 02 wait requests, 03 grant, 04 done,
// 05 port0, 06 port1, 07 status packet, 08 idle, 09 check requests, 0a end of test, 00 stop
01_01_0100_0003_0000
01_01_0101_145a_0000
02_01_0000_0000_000c
0a_01_0000_0000_0000
03_02_0000_0000_045a
04_02_0000_0000_0000
0a_02_0000_0000_0000
05_03_0090_0004_0000
0a_03_0000_0000_0000
01_04_0101_2bc1_0000
02_04_0000_0000_0002
0a_04_0000_0000_0000
03_05_0000_0001_07c1
04_05_0000_0001_0000
0a_05_0000_0000_0000
06_06_0108_0004_0000
0a_06_0000_0000_0000
01_07_0100_0001_0000
01_07_0101_0011_0000
01_07_0101_0022_0000
01_07_0102_0015_0000
07_07_0000_0000_0217
0a_07_0000_0000_0000
01_08_0100_0000_0000
01_08_0100_0001_0000
01_08_0101_0033_0000
01_08_0102_001b_0000
07_08_0000_0000_0219
01_08_0100_0003_0000
02_08_0000_0000_0008
03_08_0000_0000_0433
04_08_0000_0000_0000
07_08_0000_0000_0218
0a_08_0000_0000_0000
01_09_0102_0000_0000
01_09_0100_0003_0000
01_09_0101_1401_0000
02_09_0000_0000_000c
01_09_0100_0002_0000
08_09_0000_0006_0000
09_09_0000_0000_0000
01_09_0102_0025_0000
07_09_0000_0000_0224
0a_09_0000_0000_0000
01_0a_0100_0003_0000
01_0a_0201_1401_0000
08_0a_0000_0008_0000
09_0a_0000_0000_0000
0a_0a_0000_0000_0000
00_00_0000_0000_0000
